//--- design/cp0_reg_pkg.sv
package cp0_reg_pkg;

    // rd in [7:3], sel in [2:0]
    typedef logic [7:0] cp0_addr_t;

    localparam cp0_addr_t CR_STATUS  = 8'b01100_000;
    localparam cp0_addr_t CR_CAUSE   = 8'b01101_000;
    localparam cp0_addr_t CR_EPC     = 8'b01110_000;
    localparam cp0_addr_t CR_COUNT   = 8'b01001_000;
    localparam cp0_addr_t CR_COMPARE = 8'b01011_000;
    localparam cp0_addr_t CR_BADADDR = 8'b01000_000;

    typedef struct packed {
        logic [2:0] zero_31_29;
        logic       cu0;
        logic [4:0] zero_27_23;
        logic       bev;
        logic [5:0] zero_21_16;
        logic [7:0] im;
        logic [2:0] zero_7_5;
        logic       um;
        logic [1:0] zero_3_2;
        logic       exl;
        logic       ie;
    } status_t;

    typedef struct packed {
        logic       bd;
        logic       ti;
        // Kept internally, masked on MFC0
        logic [1:0] ce;
        logic [3:0] zero_27_24;
        logic       iv;
        logic [6:0] zero_22_16;
        logic [7:0] ip;
        logic       zero_7;
        logic [4:0] excode;
        logic [1:0] zero_1_0;
    } cause_t;

    // One CP0 data word, seen as raw bits or a register layout
    typedef union packed {
        logic [31:0] raw;
        status_t     status;
        cause_t      cause;
    } cp0_word_u;

    // BEV set, everything else clear
    localparam status_t STATUS_RESET = 32'h0040_0000;

endpackage

//--- design/cp0_exc_pkg.sv
package cp0_exc_pkg;
    import cp0_reg_pkg::*;

    typedef logic [4:0] excode_t;

    // Address-type exception codes
    localparam excode_t EXC_MOD  = 5'h01;
    localparam excode_t EXC_TLBL = 5'h02;
    localparam excode_t EXC_TLBS = 5'h03;
    localparam excode_t EXC_ADEL = 5'h04;
    localparam excode_t EXC_ADES = 5'h05;

    typedef struct packed {
        logic        we;
        cp0_addr_t   addr;
        logic [31:0] wdata;
    } mtc0_req_t;

    typedef struct packed {
        logic        ex;
        excode_t     excode;
        logic        bd;
        logic [31:0] pc;
        logic [31:0] badvaddr;
        logic        eret;
        logic [1:0]  ce;
    } exc_req_t;

    typedef struct packed {
        logic        we;
        logic [31:0] data;
    } reg_wr_t;

    typedef struct packed {
        logic       enter;
        logic       first;
        logic       eret;
        logic       addr_err;
        logic       bd;
        excode_t    excode;
        logic [1:0] ce;
    } exc_ctl_t;

endpackage

//--- design/cp0_ctrl.sv
module cp0_ctrl
    import cp0_reg_pkg::*, cp0_exc_pkg::*;
(
    input  mtc0_req_t slot1,
    input  mtc0_req_t slot2,
    input  exc_req_t  exc,
    input  logic      exl,
    output reg_wr_t   status_wr,
    output reg_wr_t   cause_wr,
    output reg_wr_t   epc_wr,
    output reg_wr_t   count_wr,
    output reg_wr_t   compare_wr,
    output exc_ctl_t  exc_ctl
);

    // Resolve both slots for one register, slot 2 wins on a tie
    function automatic reg_wr_t pick_write(
        input mtc0_req_t s1,
        input mtc0_req_t s2,
        input cp0_addr_t addr
    );
        reg_wr_t wr;
        logic    hit1;
        logic    hit2;
        hit1    = s1.we && (s1.addr == addr);
        hit2    = s2.we && (s2.addr == addr);
        wr.we   = hit1 || hit2;
        wr.data = hit2 ? s2.wdata : s1.wdata;
        return wr;
    endfunction

    always_comb begin
        status_wr  = pick_write(slot1, slot2, CR_STATUS);
        cause_wr   = pick_write(slot1, slot2, CR_CAUSE);
        epc_wr     = pick_write(slot1, slot2, CR_EPC);
        count_wr   = pick_write(slot1, slot2, CR_COUNT);
        compare_wr = pick_write(slot1, slot2, CR_COMPARE);
    end

    always_comb begin
        exc_ctl.enter    = exc.ex;
        // Nested exceptions keep EPC and BD
        exc_ctl.first    = exc.ex && !exl;
        exc_ctl.eret     = exc.eret;
        exc_ctl.addr_err = exc.ex &&
                           (exc.excode inside {EXC_MOD, EXC_TLBL, EXC_TLBS,
                                               EXC_ADEL, EXC_ADES});
        exc_ctl.bd       = exc.bd;
        exc_ctl.excode   = exc.excode;
        exc_ctl.ce       = exc.ce;
    end

endmodule

//--- design/cp0_status_cause.sv
module cp0_status_cause
    import cp0_reg_pkg::*, cp0_exc_pkg::*;
(
    input  logic      cp0_clk,
    input  logic      reset,
    input  reg_wr_t   status_wr,
    input  reg_wr_t   cause_wr,
    input  reg_wr_t   timer_wr,
    input  logic      timer_match,
    input  exc_ctl_t  exc_ctl,
    input  logic [5:0] ext_int,
    output status_t   status,
    output cause_t    cause,
    output logic      has_int
);

    status_t   status_q;
    cause_t    cause_q;
    cp0_word_u st_word;
    cp0_word_u cs_word;
    cp0_word_u cmp_word;

    assign st_word.raw  = status_wr.data;
    assign cs_word.raw  = cause_wr.data;
    assign cmp_word.raw = timer_wr.data;

    always_ff @(posedge cp0_clk) begin
        if (reset) begin
            status_q <= STATUS_RESET;
        end else begin
            if (status_wr.we) begin
                status_q.cu0 <= st_word.status.cu0;
                status_q.bev <= st_word.status.bev;
                status_q.im  <= st_word.status.im;
                status_q.um  <= st_word.status.um;
                status_q.ie  <= st_word.status.ie;
            end
            // Exception beats eret beats MTC0
            if (exc_ctl.enter) begin
                status_q.exl <= 1'b1;
            end else if (exc_ctl.eret) begin
                status_q.exl <= 1'b0;
            end else if (status_wr.we) begin
                status_q.exl <= st_word.status.exl;
            end
        end
    end

    always_ff @(posedge cp0_clk) begin
        if (reset) begin
            cause_q <= '0;
        end else begin
            if (exc_ctl.first) begin
                cause_q.bd <= exc_ctl.bd;
            end
            if (exc_ctl.enter) begin
                cause_q.excode <= exc_ctl.excode;
                cause_q.ce     <= exc_ctl.ce;
            end
            // Compare write acknowledges the timer
            if (timer_wr.we) begin
                cause_q.ti <= 1'b0;
                cause_q.iv <= cmp_word.cause.iv;
            end else if (timer_match) begin
                cause_q.ti <= 1'b1;
            end
            cause_q.ip[7]   <= ext_int[5] | cause_q.ti;
            cause_q.ip[6:2] <= ext_int[4:0];
            // Software interrupts only
            if (cause_wr.we) begin
                cause_q.ip[1:0] <= cs_word.cause.ip[1:0];
            end
        end
    end

    assign has_int = ((cause_q.ip & status_q.im) != 8'h00) &&
                     status_q.ie && !status_q.exl;

    assign status = status_q;
    assign cause  = cause_q;

endmodule

//--- design/cp0_epc_badvaddr.sv
module cp0_epc_badvaddr
    import cp0_exc_pkg::*;
(
    input  logic        cp0_clk,
    input  logic        reset,
    input  reg_wr_t     epc_wr,
    input  exc_ctl_t    exc_ctl,
    input  logic [31:0] pc,
    input  logic [31:0] badvaddr,
    output logic [31:0] epc,
    output logic [31:0] bad_vaddr
);

    always_ff @(posedge cp0_clk) begin
        if (reset) begin
            epc <= '0;
        end else if (exc_ctl.first) begin
            // Delay slot points back at the branch
            epc <= exc_ctl.bd ? pc - 32'd4 : pc;
        end else if (epc_wr.we) begin
            epc <= epc_wr.data;
        end
    end

    always_ff @(posedge cp0_clk) begin
        if (reset) begin
            bad_vaddr <= '0;
        end else if (exc_ctl.addr_err) begin
            bad_vaddr <= badvaddr;
        end
    end

endmodule

//--- design/cp0_timer.sv
module cp0_timer
    import cp0_exc_pkg::*;
#(
    parameter int COUNT_DIV = 2
) (
    input  logic        cp0_clk,
    input  logic        reset,
    input  reg_wr_t     count_wr,
    input  reg_wr_t     compare_wr,
    output logic [31:0] count,
    output logic [31:0] compare,
    output logic        timer_match
);

    localparam int DIV_W = (COUNT_DIV > 1) ? $clog2(COUNT_DIV) : 1;

    logic [DIV_W-1:0] div_q;
    logic             tick;

    assign tick = (div_q == DIV_W'(COUNT_DIV - 1));

    always_ff @(posedge cp0_clk) begin
        if (reset) begin
            div_q <= '0;
            count <= '0;
        end else begin
            div_q <= tick ? '0 : div_q + 1'b1;
            if (count_wr.we) begin
                count <= count_wr.data;
            end else if (tick) begin
                count <= count + 32'd1;
            end
        end
    end

    always_ff @(posedge cp0_clk) begin
        if (reset) begin
            compare <= '0;
        end else if (compare_wr.we) begin
            compare <= compare_wr.data;
        end
    end

    // Compare of zero disables the timer
    assign timer_match = (compare != 32'd0) && (count == compare);

endmodule

//--- design/cp0_read_mux.sv
module cp0_read_mux
    import cp0_reg_pkg::*;
(
    input  cp0_addr_t   addr,
    input  status_t     status,
    input  cause_t      cause,
    input  logic [31:0] epc,
    input  logic [31:0] bad_vaddr,
    input  logic [31:0] count,
    output logic [31:0] rdata
);

    cause_t cause_rd;

    // CE is not visible to software
    always_comb begin
        cause_rd    = cause;
        cause_rd.ce = 2'b00;
    end

    always_comb begin
        case (addr)
            CR_STATUS:  rdata = status;
            CR_CAUSE:   rdata = cause_rd;
            CR_EPC:     rdata = epc;
            CR_COUNT:   rdata = count;
            CR_BADADDR: rdata = bad_vaddr;
            default:    rdata = 32'd0;
        endcase
    end

endmodule

//--- design/cp0_top.sv
module cp0_top
    import cp0_reg_pkg::*, cp0_exc_pkg::*;
#(
    parameter int COUNT_DIV = 2
) (
    input  logic        cp0_clk,
    input  logic        reset,
    input  mtc0_req_t   slot1,
    input  mtc0_req_t   slot2,
    input  exc_req_t    exc,
    input  logic [5:0]  ext_int,
    output logic [31:0] rdata1,
    output logic [31:0] rdata2,
    output logic        has_int,
    output logic [31:0] epc_res
);

    reg_wr_t     status_wr;
    reg_wr_t     cause_wr;
    reg_wr_t     epc_wr;
    reg_wr_t     count_wr;
    reg_wr_t     compare_wr;
    exc_ctl_t    exc_ctl;
    status_t     status;
    cause_t      cause;
    logic [31:0] epc;
    logic [31:0] bad_vaddr;
    logic [31:0] count;
    logic        timer_match;

    cp0_ctrl u_ctrl (
        .slot1      (slot1),
        .slot2      (slot2),
        .exc        (exc),
        .exl        (status.exl),
        .status_wr  (status_wr),
        .cause_wr   (cause_wr),
        .epc_wr     (epc_wr),
        .count_wr   (count_wr),
        .compare_wr (compare_wr),
        .exc_ctl    (exc_ctl)
    );

    cp0_status_cause u_status_cause (
        .cp0_clk     (cp0_clk),
        .reset       (reset),
        .status_wr   (status_wr),
        .cause_wr    (cause_wr),
        .timer_wr    (compare_wr),
        .timer_match (timer_match),
        .exc_ctl     (exc_ctl),
        .ext_int     (ext_int),
        .status      (status),
        .cause       (cause),
        .has_int     (has_int)
    );

    cp0_epc_badvaddr u_epc_badvaddr (
        .cp0_clk   (cp0_clk),
        .reset     (reset),
        .epc_wr    (epc_wr),
        .exc_ctl   (exc_ctl),
        .pc        (exc.pc),
        .badvaddr  (exc.badvaddr),
        .epc       (epc),
        .bad_vaddr (bad_vaddr)
    );

    // Compare has no read path
    cp0_timer #(
        .COUNT_DIV (COUNT_DIV)
    ) u_timer (
        .cp0_clk     (cp0_clk),
        .reset       (reset),
        .count_wr    (count_wr),
        .compare_wr  (compare_wr),
        .count       (count),
        .compare     (),
        .timer_match (timer_match)
    );

    cp0_read_mux u_read_mux1 (
        .addr      (slot1.addr),
        .status    (status),
        .cause     (cause),
        .epc       (epc),
        .bad_vaddr (bad_vaddr),
        .count     (count),
        .rdata     (rdata1)
    );

    cp0_read_mux u_read_mux2 (
        .addr      (slot2.addr),
        .status    (status),
        .cause     (cause),
        .epc       (epc),
        .bad_vaddr (bad_vaddr),
        .count     (count),
        .rdata     (rdata2)
    );

    assign epc_res = epc;

endmodule

//--- tb/cp0_props.sv
module cp0_props
    import cp0_reg_pkg::*, cp0_exc_pkg::*;
(
    input logic     cp0_clk,
    input logic     reset,
    input reg_wr_t  status_wr,
    input reg_wr_t  timer_wr,
    input exc_ctl_t exc_ctl,
    input status_t  status_q,
    input cause_t   cause_q,
    input logic     has_int
);

    // EXL holds and masks every interrupt until eret or MTC0
    no_int_in_exl: assert property (@(posedge cp0_clk) disable iff (reset)
        status_q.exl && !exc_ctl.eret && !status_wr.we |=> !has_int)
        else $error("has_int went high while Status.EXL was held");

    exl_after_enter: assert property (@(posedge cp0_clk) disable iff (reset)
        exc_ctl.enter |=> status_q.exl)
        else $error("Status.EXL not set the cycle after an exception");

    ti_clear_on_compare: assert property (@(posedge cp0_clk) disable iff (reset)
        timer_wr.we |=> !cause_q.ti)
        else $error("Cause.TI still set the cycle after a Compare write");

endmodule

bind cp0_status_cause cp0_props u_props (
    .cp0_clk   (cp0_clk),
    .reset     (reset),
    .status_wr (status_wr),
    .timer_wr  (timer_wr),
    .exc_ctl   (exc_ctl),
    .status_q  (status_q),
    .cause_q   (cause_q),
    .has_int   (has_int)
);

//--- tb/cp0_checker.sv
module cp0_checker (
    input  logic        cp0_clk,
    input  logic        reset,
    input  logic [31:0] rdata1,
    input  logic [31:0] rdata2,
    input  logic        has_int,
    input  logic [31:0] epc_res,
    input  logic        chk_en,
    input  logic [1:0]  chk_sig,
    input  logic [31:0] chk_exp,
    input  logic [31:0] chk_mask,
    input  logic [15:0] chk_id,
    output int          pass_cnt,
    output int          fail_cnt
);

    logic [31:0] got;

    function automatic string sig_name(input logic [1:0] sel);
        case (sel)
            2'd0:    return "rdata1";
            2'd1:    return "rdata2";
            2'd2:    return "has_int";
            default: return "epc_res";
        endcase
    endfunction

    always_comb begin
        case (chk_sig)
            2'd0:    got = rdata1;
            2'd1:    got = rdata2;
            2'd2:    got = {31'd0, has_int};
            default: got = epc_res;
        endcase
    end

    // Inputs settle at the falling edge, compare at the rising one
    always @(posedge cp0_clk) begin
        if (reset) begin
            pass_cnt <= 0;
            fail_cnt <= 0;
        end else if (chk_en) begin
            if ((got & chk_mask) == (chk_exp & chk_mask)) begin
                pass_cnt <= pass_cnt + 1;
                $display("test %0d ok: %s = %h", chk_id, sig_name(chk_sig), got & chk_mask);
            end else begin
                fail_cnt <= fail_cnt + 1;
                $display("ERROR test %0d: %s = %h, expected %h (mask %h)", chk_id,
                         sig_name(chk_sig), got & chk_mask, chk_exp & chk_mask, chk_mask);
            end
        end
    end

endmodule

//--- tb/cp0_tb.sv
module cp0_tb
    import cp0_reg_pkg::*, cp0_exc_pkg::*;
();

    localparam int K_WR    = 0;
    localparam int K_RD    = 1;
    localparam int K_EXC   = 2;
    localparam int K_ERET  = 3;
    localparam int K_IRQ   = 4;
    localparam int K_TWAIT = 5;
    localparam int K_HINT  = 6;
    localparam int K_EPC   = 7;

    typedef struct packed {
        logic [2:0]  kind;
        logic [1:0]  slot;
        cp0_addr_t   addr;
        logic [31:0] d1;
        logic [31:0] d2;
        logic [4:0]  excode;
        logic        bd;
        logic [31:0] exp;
        logic [31:0] mask;
    } row_t;

    logic        cp0_clk = 1'b0;
    logic        reset;
    mtc0_req_t   slot1;
    mtc0_req_t   slot2;
    exc_req_t    exc;
    logic [5:0]  ext_int;
    logic [31:0] rdata1;
    logic [31:0] rdata2;
    logic        has_int;
    logic [31:0] epc_res;
    logic        chk_en;
    logic [1:0]  chk_sig;
    logic [31:0] chk_exp;
    logic [31:0] chk_mask;
    logic [15:0] chk_id;
    int          pass_cnt;
    int          fail_cnt;
    row_t        rows[$];
    logic [31:0] seed = 32'h99f6;
    int          cycles = 0;
    int          cycle_limit = 0;

    always #10 cp0_clk = ~cp0_clk;

    cp0_top #(.COUNT_DIV(2)) uut (
        .cp0_clk (cp0_clk),
        .reset   (reset),
        .slot1   (slot1),
        .slot2   (slot2),
        .exc     (exc),
        .ext_int (ext_int),
        .rdata1  (rdata1),
        .rdata2  (rdata2),
        .has_int (has_int),
        .epc_res (epc_res)
    );

    cp0_checker u_checker (
        .cp0_clk  (cp0_clk),
        .reset    (reset),
        .rdata1   (rdata1),
        .rdata2   (rdata2),
        .has_int  (has_int),
        .epc_res  (epc_res),
        .chk_en   (chk_en),
        .chk_sig  (chk_sig),
        .chk_exp  (chk_exp),
        .chk_mask (chk_mask),
        .chk_id   (chk_id),
        .pass_cnt (pass_cnt),
        .fail_cnt (fail_cnt)
    );

    // LCG step with the Numerical Recipes constants
    function automatic logic [31:0] next_rand();
        seed = seed * 32'd1664525 + 32'd1013904223;
        return seed;
    endfunction

    // Pending and enabled interrupt while IE is set and EXL is clear
    function automatic logic [31:0] int_rule(input logic [7:0] ip, input logic [7:0] im,
                                             input logic ie, input logic exl);
        return {31'd0, ((ip & im) != 8'h00) && ie && !exl};
    endfunction

    task automatic add_row(input int kind, input int slot, input cp0_addr_t addr,
                           input logic [31:0] d1, input logic [31:0] d2, input int code,
                           input int bd, input logic [31:0] exp, input logic [31:0] mask);
        row_t row;
        row.kind   = 3'(kind);
        row.slot   = 2'(slot);
        row.addr   = addr;
        row.d1     = d1;
        row.d2     = d2;
        row.excode = 5'(code);
        row.bd     = (bd != 0);
        row.exp    = exp;
        row.mask   = mask;
        rows.push_back(row);
    endtask

    task automatic apply_row(input int n, input row_t row);
        int waited;
        @(negedge cp0_clk);
        slot1   = '0;
        slot2   = '0;
        exc     = '0;
        chk_en  = 1'b0;
        chk_sig = 2'd0;
        chk_id  = 16'(n);
        case (row.kind)
            3'(K_WR): begin
                slot1.we    = row.slot[0];
                slot1.addr  = row.addr;
                slot1.wdata = row.d1;
                slot2.we    = row.slot[1];
                slot2.addr  = row.addr;
                slot2.wdata = row.d2;
            end
            3'(K_RD): begin
                slot1.addr = row.addr;
                slot2.addr = row.addr;
                chk_en     = 1'b1;
                chk_sig    = (row.slot == 2'd2) ? 2'd1 : 2'd0;
            end
            3'(K_EXC): begin
                exc.ex       = 1'b1;
                exc.excode   = row.excode;
                exc.bd       = row.bd;
                exc.pc       = row.d1;
                exc.badvaddr = row.d2;
            end
            3'(K_ERET): exc.eret = 1'b1;
            3'(K_IRQ):  ext_int = row.d1[5:0];
            3'(K_TWAIT): begin
                // Poll Cause.TI for up to 10 cycles
                slot1.addr = CR_CAUSE;
                waited = 0;
                do begin
                    @(negedge cp0_clk);
                    waited++;
                end while (!rdata1[30] && waited < 10);
            end
            3'(K_HINT): begin
                chk_en  = 1'b1;
                chk_sig = 2'd2;
            end
            default: begin
                chk_en  = 1'b1;
                chk_sig = 2'd3;
            end
        endcase
        chk_exp  = row.exp;
        chk_mask = row.mask;
    endtask

    always @(posedge cp0_clk) begin
        cycles <= cycles + 1;
        if (cycle_limit > 0 && cycles >= cycle_limit) begin
            $display("Run stopped: no result after %0d cycles", cycles);
            $display("Simulation finished: FAIL");
            $finish;
        end
    end

    initial begin : main
        cp0_addr_t   wr_addr[3];
        logic [31:0] wr_mask[3];
        logic [31:0] r1;
        logic [31:0] r2;
        logic [31:0] pc;
        logic [31:0] bad;
        logic [31:0] c;
        reset    = 1'b1;
        slot1    = '0;
        slot2    = '0;
        exc      = '0;
        ext_int  = '0;
        chk_en   = 1'b0;
        chk_sig  = 2'd0;
        chk_exp  = '0;
        chk_mask = '0;
        chk_id   = '0;
        wr_addr  = '{CR_STATUS, CR_CAUSE, CR_EPC};
        // Writable fields per register
        wr_mask  = '{32'h1040_FF13, 32'h0000_0300, 32'hFFFF_FFFF};

        // Values right after reset
        add_row(K_RD, 1, CR_STATUS, 0, 0, 0, 0, 32'h0040_0000, '1);
        add_row(K_RD, 2, CR_CAUSE, 0, 0, 0, 0, 0, '1);
        add_row(K_RD, 1, CR_EPC, 0, 0, 0, 0, 0, '1);
        add_row(K_RD, 2, CR_BADADDR, 0, 0, 0, 0, 0, '1);
        add_row(K_HINT, 0, 8'h00, 0, 0, 0, 0, 0, '1);

        for (int k = 0; k < 3; k++) begin
            for (int i = 0; i < 2; i++) begin
                r1 = next_rand();
                add_row(K_WR, i + 1, wr_addr[k], r1, r1, 0, 0, 0, 0);
                add_row(K_RD, 1, wr_addr[k], 0, 0, 0, 0, r1 & wr_mask[k], '1);
                add_row(K_RD, 2, wr_addr[k], 0, 0, 0, 0, r1 & wr_mask[k], '1);
            end
            // Same register from both slots
            r1 = next_rand();
            r2 = next_rand();
            add_row(K_WR, 3, wr_addr[k], r1, r2, 0, 0, 0, 0);
            add_row(K_RD, 1, wr_addr[k], 0, 0, 0, 0, r2 & wr_mask[k], '1);
        end

        // First exception is an AdEL outside a delay slot
        pc  = next_rand();
        bad = next_rand();
        add_row(K_WR, 1, CR_STATUS, 32'h0040_0000, 0, 0, 0, 0, 0);
        add_row(K_EXC, 0, 8'h00, pc, bad, 4, 0, 0, 0);
        add_row(K_RD, 1, CR_EPC, 0, 0, 0, 0, pc, '1);
        add_row(K_EPC, 0, 8'h00, 0, 0, 0, 0, pc, '1);
        add_row(K_RD, 2, CR_BADADDR, 0, 0, 0, 0, bad, '1);
        add_row(K_RD, 1, CR_CAUSE, 0, 0, 0, 0, 32'h0000_0010, 32'h8000_007C);
        add_row(K_RD, 2, CR_STATUS, 0, 0, 0, 0, 32'h0000_0002, 32'h0000_0002);
        add_row(K_HINT, 0, 8'h00, 0, 0, 0, 0, 0, '1);
        // Nested syscall leaves EPC, BD and BadVAddr
        add_row(K_EXC, 0, 8'h00, next_rand(), next_rand(), 8, 1, 0, 0);
        add_row(K_RD, 1, CR_EPC, 0, 0, 0, 0, pc, '1);
        add_row(K_RD, 2, CR_BADADDR, 0, 0, 0, 0, bad, '1);
        add_row(K_RD, 1, CR_CAUSE, 0, 0, 0, 0, 32'h0000_0020, 32'h8000_007C);
        add_row(K_ERET, 0, 8'h00, 0, 0, 0, 0, 0, 0);
        add_row(K_RD, 1, CR_STATUS, 0, 0, 0, 0, 0, 32'h0000_0002);
        // Delay slot exception
        pc = next_rand();
        add_row(K_EXC, 0, 8'h00, pc, next_rand(), 8, 1, 0, 0);
        add_row(K_RD, 2, CR_EPC, 0, 0, 0, 0, pc - 32'd4, '1);
        add_row(K_RD, 1, CR_CAUSE, 0, 0, 0, 0, 32'h8000_0020, 32'h8000_007C);
        add_row(K_RD, 2, CR_BADADDR, 0, 0, 0, 0, bad, '1);
        add_row(K_ERET, 0, 8'h00, 0, 0, 0, 0, 0, 0);

        // Timer with IM[7] and IE enabled
        c = next_rand();
        add_row(K_WR, 1, CR_STATUS, 32'h0000_8001, 0, 0, 0, 0, 0);
        add_row(K_WR, 1, CR_COUNT, c, 0, 0, 0, 0, 0);
        add_row(K_WR, 2, CR_COMPARE, 0, c + 32'd3, 0, 0, 0, 0);
        add_row(K_TWAIT, 0, 8'h00, 0, 0, 0, 0, 0, 0);
        add_row(K_RD, 1, CR_CAUSE, 0, 0, 0, 0, 32'h4000_0000, 32'h4000_0000);
        add_row(K_HINT, 0, 8'h00, 0, 0, 0, 0, int_rule(8'h80, 8'h80, 1'b1, 1'b0), '1);
        add_row(K_WR, 1, CR_COMPARE, 0, 0, 0, 0, 0, 0);
        add_row(K_RD, 2, CR_CAUSE, 0, 0, 0, 0, 0, 32'h4000_0000);
        add_row(K_HINT, 0, 8'h00, 0, 0, 0, 0, int_rule(8'h00, 8'h80, 1'b1, 1'b0), '1);

        // External and software interrupts
        add_row(K_WR, 1, CR_CAUSE, 0, 0, 0, 0, 0, 0);
        add_row(K_IRQ, 0, 8'h00, 32'h04, 0, 0, 0, 0, 0);
        add_row(K_RD, 1, CR_CAUSE, 0, 0, 0, 0, 32'h0000_1000, 32'h0000_FF00);
        add_row(K_HINT, 0, 8'h00, 0, 0, 0, 0, int_rule(8'h10, 8'h80, 1'b1, 1'b0), '1);
        add_row(K_WR, 2, CR_STATUS, 0, 32'h0000_1001, 0, 0, 0, 0);
        add_row(K_HINT, 0, 8'h00, 0, 0, 0, 0, int_rule(8'h10, 8'h10, 1'b1, 1'b0), '1);
        add_row(K_IRQ, 0, 8'h00, 0, 0, 0, 0, 0, 0);
        add_row(K_WR, 1, CR_CAUSE, 32'h0000_0100, 0, 0, 0, 0, 0);
        add_row(K_RD, 2, CR_CAUSE, 0, 0, 0, 0, 32'h0000_0100, 32'h0000_FF00);
        add_row(K_WR, 1, CR_STATUS, 32'h0000_0101, 0, 0, 0, 0, 0);
        add_row(K_HINT, 0, 8'h00, 0, 0, 0, 0, int_rule(8'h01, 8'h01, 1'b1, 1'b0), '1);
        add_row(K_WR, 1, CR_STATUS, 32'h0000_0103, 0, 0, 0, 0, 0);
        add_row(K_HINT, 0, 8'h00, 0, 0, 0, 0, int_rule(8'h01, 8'h01, 1'b1, 1'b1), '1);
        add_row(K_IRQ, 0, 8'h00, 32'h20, 0, 0, 0, 0, 0);
        add_row(K_RD, 1, CR_CAUSE, 0, 0, 0, 0, 32'h0000_8100, 32'h0000_FF00);
        add_row(K_IRQ, 0, 8'h00, 0, 0, 0, 0, 0, 0);

        cycle_limit = rows.size() * 8 + 200;

        repeat (2) @(posedge cp0_clk);
        @(negedge cp0_clk);
        reset = 1'b0;

        foreach (rows[n]) begin
            apply_row(n, rows[n]);
        end
        @(negedge cp0_clk);
        slot1  = '0;
        slot2  = '0;
        exc    = '0;
        chk_en = 1'b0;
        @(negedge cp0_clk);

        $display("Checks done: %0d passed, %0d failed", pass_cnt, fail_cnt);
        if (fail_cnt == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule

//--- files.f
design/cp0_reg_pkg.sv
design/cp0_exc_pkg.sv
design/cp0_ctrl.sv
design/cp0_status_cause.sv
design/cp0_epc_badvaddr.sv
design/cp0_timer.sv
design/cp0_read_mux.sv
design/cp0_top.sv
tb/cp0_props.sv
tb/cp0_checker.sv
tb/cp0_tb.sv

//--- run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module cp0_tb -f files.f

# The pass line decides the result
if ./obj_dir/Vcp0_tb | tee /dev/stderr | grep -x "Simulation finished: PASS" > /dev/null; then
    exit 0
else
    exit 1
fi
